/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = soc_bus_tb
FILELIST  = sources.f
LOG       = sim.log
FAIL_MSG  = *** TEST FAILED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir $(LOG)

/* design/addr_router.sv */
/*
 * addr_router: SRAM / timer address decode and response return mux
 * unmapped addresses get a decode error one cycle after acceptance
 */
`timescale 1ns/100ps
`default_nettype none
`include "bus_macros.svh"

module addr_router (
	input  logic       clk,
	input  logic       rst_n,
	axi_lite_if.slave  up,
	axi_lite_if.master mem,
	axi_lite_if.master tmr
);

	logic                 ar_mem, ar_tmr, aw_mem, aw_tmr;
	logic                 rd_busy, rd_tmr, rd_err;
	logic                 wr_busy, wr_tmr, wr_err;
	logic [`BUS_ID_W-1:0] rd_err_id, wr_err_id;

	function automatic logic in_mem(input logic [`BUS_ADDR_W-1:0] a);
		return (a >= `MEM_BASE) && (a < `MEM_BASE + `MEM_WORDS * 8);
	endfunction

	function automatic logic in_tmr(input logic [`BUS_ADDR_W-1:0] a);
		return (a >= `TIMER_BASE) && (a < `TIMER_BASE + `TIMER_SPAN);
	endfunction

	assign ar_mem = in_mem(up.araddr);
	assign ar_tmr = in_tmr(up.araddr);
	assign aw_mem = in_mem(up.awaddr);
	assign aw_tmr = in_tmr(up.awaddr);

	// requests steered only while the direction is free
	assign mem.arvalid = up.arvalid & ~rd_busy & ar_mem;
	assign tmr.arvalid = up.arvalid & ~rd_busy & ar_tmr;
	assign mem.arid    = up.arid;
	assign mem.araddr  = up.araddr;
	assign tmr.arid    = up.arid;
	assign tmr.araddr  = up.araddr;
	assign up.arready  = ~rd_busy & (ar_mem ? mem.arready : (ar_tmr ? tmr.arready : 1'b1));

	assign mem.awvalid = up.awvalid & ~wr_busy & aw_mem;
	assign tmr.awvalid = up.awvalid & ~wr_busy & aw_tmr;
	assign mem.awid    = up.awid;
	assign mem.awaddr  = up.awaddr;
	assign mem.wdata   = up.wdata;
	assign mem.wstrb   = up.wstrb;
	assign tmr.awid    = up.awid;
	assign tmr.awaddr  = up.awaddr;
	assign tmr.wdata   = up.wdata;
	assign tmr.wstrb   = up.wstrb;
	assign up.awready  = ~wr_busy & (aw_mem ? mem.awready : (aw_tmr ? tmr.awready : 1'b1));

	always_comb begin
		up.rvalid  = rd_busy & rd_err;
		up.rid     = rd_err_id;
		up.rdata   = '0;
		up.rresp   = bus_pkg::RESP_DECERR;
		mem.rready = 1'b0;
		tmr.rready = 1'b0;
		if (rd_busy && !rd_err) begin
			if (rd_tmr) begin
				up.rvalid  = tmr.rvalid;
				up.rid     = tmr.rid;
				up.rdata   = tmr.rdata;
				up.rresp   = tmr.rresp;
				tmr.rready = up.rready;
			end else begin
				up.rvalid  = mem.rvalid;
				up.rid     = mem.rid;
				up.rdata   = mem.rdata;
				up.rresp   = mem.rresp;
				mem.rready = up.rready;
			end
		end
	end

	always_comb begin
		up.bvalid  = wr_busy & wr_err;
		up.bid     = wr_err_id;
		up.bresp   = bus_pkg::RESP_DECERR;
		mem.bready = 1'b0;
		tmr.bready = 1'b0;
		if (wr_busy && !wr_err) begin
			if (wr_tmr) begin
				up.bvalid  = tmr.bvalid;
				up.bid     = tmr.bid;
				up.bresp   = tmr.bresp;
				tmr.bready = up.bready;
			end else begin
				up.bvalid  = mem.bvalid;
				up.bid     = mem.bid;
				up.bresp   = mem.bresp;
				mem.bready = up.bready;
			end
		end
	end

	// target held from address acceptance to response completion
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_busy <= 1'b0;
			rd_tmr  <= 1'b0;
			rd_err  <= 1'b0;
		end else if (!rd_busy) begin
			if (up.arvalid && up.arready) begin
				rd_busy <= 1'b1;
				rd_tmr  <= ar_tmr;
				rd_err  <= !ar_mem && !ar_tmr;
			end
		end else if (up.rvalid && up.rready) begin
			rd_busy <= 1'b0;
			rd_err  <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_busy <= 1'b0;
			wr_tmr  <= 1'b0;
			wr_err  <= 1'b0;
		end else if (!wr_busy) begin
			if (up.awvalid && up.awready) begin
				wr_busy <= 1'b1;
				wr_tmr  <= aw_tmr;
				wr_err  <= !aw_mem && !aw_tmr;
			end
		end else if (up.bvalid && up.bready) begin
			wr_busy <= 1'b0;
			wr_err  <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (up.arvalid && up.arready)
			rd_err_id <= up.arid;
		if (up.awvalid && up.awready)
			wr_err_id <= up.awid;
	end

endmodule

`default_nettype wire

/* design/axi_lite_if.sv */
/*
 * axi_lite_if: single-beat AXI-lite link, write address and data combined
 * master and slave modports
 */
`timescale 1ns/100ps
`default_nettype none
`include "bus_macros.svh"

interface axi_lite_if;
	logic                   arvalid;
	logic                   arready;
	logic [`BUS_ID_W-1:0]   arid;
	logic [`BUS_ADDR_W-1:0] araddr;
	logic                   rvalid;
	logic                   rready;
	logic [`BUS_ID_W-1:0]   rid;
	logic [`BUS_DATA_W-1:0] rdata;
	bus_pkg::resp_t         rresp;
	logic                   awvalid;
	logic                   awready;
	logic [`BUS_ID_W-1:0]   awid;
	logic [`BUS_ADDR_W-1:0] awaddr;
	logic [`BUS_DATA_W-1:0] wdata;
	logic [`BUS_STRB_W-1:0] wstrb;
	logic                   bvalid;
	logic                   bready;
	logic [`BUS_ID_W-1:0]   bid;
	bus_pkg::resp_t         bresp;

	modport master (
		output arvalid, arid, araddr, rready, awvalid, awid, awaddr, wdata, wstrb, bready,
		input  arready, rvalid, rid, rdata, rresp, awready, bvalid, bid, bresp
	);

	modport slave (
		input  arvalid, arid, araddr, rready, awvalid, awid, awaddr, wdata, wstrb, bready,
		output arready, rvalid, rid, rdata, rresp, awready, bvalid, bid, bresp
	);
endinterface

`default_nettype wire

/* design/bus_arbiter.sv */
/*
 * bus_arbiter: read FSM granting data over fetch, write FSM for data only
 * one transaction per direction, response returned to the granted master
 */
`timescale 1ns/100ps
`default_nettype none
`include "bus_macros.svh"

module bus_arbiter (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   if_arvalid,
	output logic                   if_arready,
	input  logic [`BUS_ID_W-1:0]   if_arid,
	input  logic [`BUS_ADDR_W-1:0] if_araddr,
	output logic                   if_rvalid,
	input  logic                   if_rready,
	output logic [`BUS_ID_W-1:0]   if_rid,
	output logic [`BUS_DATA_W-1:0] if_rdata,
	output bus_pkg::resp_t         if_rresp,
	input  logic                   mem_arvalid,
	output logic                   mem_arready,
	input  logic [`BUS_ID_W-1:0]   mem_arid,
	input  logic [`BUS_ADDR_W-1:0] mem_araddr,
	output logic                   mem_rvalid,
	input  logic                   mem_rready,
	output logic [`BUS_ID_W-1:0]   mem_rid,
	output logic [`BUS_DATA_W-1:0] mem_rdata,
	output bus_pkg::resp_t         mem_rresp,
	input  logic                   mem_awvalid,
	output logic                   mem_awready,
	input  logic [`BUS_ID_W-1:0]   mem_awid,
	input  logic [`BUS_ADDR_W-1:0] mem_awaddr,
	input  logic [`BUS_DATA_W-1:0] mem_wdata,
	input  logic [`BUS_STRB_W-1:0] mem_wstrb,
	output logic                   mem_bvalid,
	input  logic                   mem_bready,
	output logic [`BUS_ID_W-1:0]   mem_bid,
	output bus_pkg::resp_t         mem_bresp,
	axi_lite_if.master             down
);

	bus_pkg::arb_state_t rd_state;
	bus_pkg::arb_state_t wr_state;
	bus_pkg::master_t    rd_owner;
	logic                rd_data;
	logic                rd_addr;
	logic                rd_resp;

	// read direction, data master wins a tie
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_state <= bus_pkg::ARB_IDLE;
			rd_owner <= bus_pkg::MST_FETCH;
		end else begin
			case (rd_state)
				bus_pkg::ARB_IDLE: begin
					if (mem_arvalid) begin
						rd_owner <= bus_pkg::MST_DATA;
						rd_state <= bus_pkg::ARB_ADDR;
					end else if (if_arvalid) begin
						rd_owner <= bus_pkg::MST_FETCH;
						rd_state <= bus_pkg::ARB_ADDR;
					end
				end
				bus_pkg::ARB_ADDR: begin
					if (down.arvalid && down.arready)
						rd_state <= bus_pkg::ARB_RESP;
				end
				default: begin
					if (down.rvalid && down.rready)
						rd_state <= bus_pkg::ARB_IDLE;
				end
			endcase
		end
	end

	assign rd_data = (rd_owner == bus_pkg::MST_DATA);
	assign rd_addr = (rd_state == bus_pkg::ARB_ADDR);
	assign rd_resp = (rd_state == bus_pkg::ARB_RESP);

	assign down.arvalid = rd_addr & (rd_data ? mem_arvalid : if_arvalid);
	assign down.arid    = rd_data ? mem_arid : if_arid;
	assign down.araddr  = rd_data ? mem_araddr : if_araddr;
	assign mem_arready  = rd_addr & rd_data & down.arready;
	assign if_arready   = rd_addr & ~rd_data & down.arready;

	// payload shared, only the owner sees rvalid
	assign mem_rvalid  = rd_resp & rd_data & down.rvalid;
	assign if_rvalid   = rd_resp & ~rd_data & down.rvalid;
	assign down.rready = rd_resp & (rd_data ? mem_rready : if_rready);
	assign mem_rid     = down.rid;
	assign mem_rdata   = down.rdata;
	assign mem_rresp   = down.rresp;
	assign if_rid      = down.rid;
	assign if_rdata    = down.rdata;
	assign if_rresp    = down.rresp;

	// write direction, data master only
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_state <= bus_pkg::ARB_IDLE;
		end else begin
			case (wr_state)
				bus_pkg::ARB_IDLE: begin
					if (mem_awvalid)
						wr_state <= bus_pkg::ARB_ADDR;
				end
				bus_pkg::ARB_ADDR: begin
					if (down.awvalid && down.awready)
						wr_state <= bus_pkg::ARB_RESP;
				end
				default: begin
					if (down.bvalid && down.bready)
						wr_state <= bus_pkg::ARB_IDLE;
				end
			endcase
		end
	end

	assign down.awvalid = (wr_state == bus_pkg::ARB_ADDR) & mem_awvalid;
	assign down.awid    = mem_awid;
	assign down.awaddr  = mem_awaddr;
	assign down.wdata   = mem_wdata;
	assign down.wstrb   = mem_wstrb;
	assign mem_awready  = (wr_state == bus_pkg::ARB_ADDR) & down.awready;
	assign mem_bvalid   = (wr_state == bus_pkg::ARB_RESP) & down.bvalid;
	assign down.bready  = (wr_state == bus_pkg::ARB_RESP) & mem_bready;
	assign mem_bid      = down.bid;
	assign mem_bresp    = down.bresp;

endmodule

`default_nettype wire

/* design/bus_macros.svh */
/*
 * bus widths, address map and SRAM depth
 */
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

`define BUS_ADDR_W 32
`define BUS_DATA_W 64
`define BUS_STRB_W 8
`define BUS_ID_W 4

`define MEM_BASE 32'h0000_0000
`define MEM_WORDS 512

`define TIMER_BASE 32'h0200_0000
`define TIMER_SPAN 32'h0001_0000
`define TIMER_MTIMECMP (`TIMER_BASE + 32'h0000_4000)
`define TIMER_MTIME (`TIMER_BASE + 32'h0000_BFF8)

`endif

/* design/bus_pkg.sv */
/*
 * bus_pkg: arbiter state, response code and master id enums
 */
`default_nettype none

package bus_pkg;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_ADDR,
		ARB_RESP
	} arb_state_t;

	// AXI response encodings, EXOKAY unused
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_t;

	typedef enum logic {
		MST_FETCH,
		MST_DATA
	} master_t;

endpackage

`default_nettype wire

/* design/mtimer.sv */
/*
 * mtimer: free-running mtime, mtimecmp compare and timer interrupt
 * other offsets in the window answer with a slave error
 */
`timescale 1ns/100ps
`default_nettype none
`include "bus_macros.svh"

module mtimer (
	input  logic      clk,
	input  logic      rst_n,
	axi_lite_if.slave bus,
	output logic      irq
);

	logic [`BUS_DATA_W-1:0] mtime, mtimecmp;
	logic                   rvalid_q, bvalid_q;
	logic [`BUS_DATA_W-1:0] rdata_q;
	logic [`BUS_ID_W-1:0]   rid_q, bid_q;
	bus_pkg::resp_t         rresp_q, bresp_q;
	logic                   rd_go, wr_go, wr_time, wr_cmp;

	function automatic logic [`BUS_DATA_W-1:0] merge(
		input logic [`BUS_DATA_W-1:0] old,
		input logic [`BUS_DATA_W-1:0] data,
		input logic [`BUS_STRB_W-1:0] strb
	);
		logic [`BUS_DATA_W-1:0] res;
		res = old;
		for (int i = 0; i < `BUS_STRB_W; i++) begin
			if (strb[i])
				res[8*i +: 8] = data[8*i +: 8];
		end
		return res;
	endfunction

	assign bus.arready = ~rvalid_q;
	assign bus.awready = ~bvalid_q;
	assign rd_go       = bus.arvalid & bus.arready;
	assign wr_go       = bus.awvalid & bus.awready;
	assign wr_time     = wr_go & (bus.awaddr == `TIMER_MTIME);
	assign wr_cmp      = wr_go & (bus.awaddr == `TIMER_MTIMECMP);

	assign bus.rvalid = rvalid_q;
	assign bus.rid    = rid_q;
	assign bus.rdata  = rdata_q;
	assign bus.rresp  = rresp_q;
	assign bus.bvalid = bvalid_q;
	assign bus.bid    = bid_q;
	assign bus.bresp  = bresp_q;

	assign irq = (mtime >= mtimecmp);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime    <= '0;
			mtimecmp <= '1;
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			// a write replaces this cycle's increment
			if (wr_time)
				mtime <= merge(mtime, bus.wdata, bus.wstrb);
			else
				mtime <= mtime + 1'b1;
			if (wr_cmp)
				mtimecmp <= merge(mtimecmp, bus.wdata, bus.wstrb);
			if (rd_go)
				rvalid_q <= 1'b1;
			else if (bus.rready)
				rvalid_q <= 1'b0;
			if (wr_go)
				bvalid_q <= 1'b1;
			else if (bus.bready)
				bvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_go) begin
			rid_q <= bus.arid;
			case (bus.araddr)
				`TIMER_MTIME: begin
					rdata_q <= mtime;
					rresp_q <= bus_pkg::RESP_OKAY;
				end
				`TIMER_MTIMECMP: begin
					rdata_q <= mtimecmp;
					rresp_q <= bus_pkg::RESP_OKAY;
				end
				default: begin
					rdata_q <= '0;
					rresp_q <= bus_pkg::RESP_SLVERR;
				end
			endcase
		end
		if (wr_go) begin
			bid_q   <= bus.awid;
			bresp_q <= (wr_time || wr_cmp) ? bus_pkg::RESP_OKAY : bus_pkg::RESP_SLVERR;
		end
	end

endmodule

`default_nettype wire

/* design/soc_bus_top.sv */
/*
 * soc_bus_top: fetch and data master ports, arbiter, router,
 * SRAM and machine timer slaves
 */
`timescale 1ns/100ps
`default_nettype none
`include "bus_macros.svh"

module soc_bus_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   if_arvalid,
	output logic                   if_arready,
	input  logic [`BUS_ID_W-1:0]   if_arid,
	input  logic [`BUS_ADDR_W-1:0] if_araddr,
	output logic                   if_rvalid,
	input  logic                   if_rready,
	output logic [`BUS_ID_W-1:0]   if_rid,
	output logic [`BUS_DATA_W-1:0] if_rdata,
	output bus_pkg::resp_t         if_rresp,
	input  logic                   mem_arvalid,
	output logic                   mem_arready,
	input  logic [`BUS_ID_W-1:0]   mem_arid,
	input  logic [`BUS_ADDR_W-1:0] mem_araddr,
	output logic                   mem_rvalid,
	input  logic                   mem_rready,
	output logic [`BUS_ID_W-1:0]   mem_rid,
	output logic [`BUS_DATA_W-1:0] mem_rdata,
	output bus_pkg::resp_t         mem_rresp,
	input  logic                   mem_awvalid,
	output logic                   mem_awready,
	input  logic [`BUS_ID_W-1:0]   mem_awid,
	input  logic [`BUS_ADDR_W-1:0] mem_awaddr,
	input  logic [`BUS_DATA_W-1:0] mem_wdata,
	input  logic [`BUS_STRB_W-1:0] mem_wstrb,
	output logic                   mem_bvalid,
	input  logic                   mem_bready,
	output logic [`BUS_ID_W-1:0]   mem_bid,
	output bus_pkg::resp_t         mem_bresp,
	output logic                   timer_irq
);

	axi_lite_if arb_bus ();
	axi_lite_if mem_bus ();
	axi_lite_if tmr_bus ();

	// master ports share their names with the arbiter ports
	bus_arbiter u_arb (
		.down (arb_bus.master),
		.*
	);

	addr_router u_router (
		.clk  (clk),
		.rst_n(rst_n),
		.up   (arb_bus.slave),
		.mem  (mem_bus.master),
		.tmr  (tmr_bus.master)
	);

	sram_slave u_sram (
		.clk  (clk),
		.rst_n(rst_n),
		.bus  (mem_bus.slave)
	);

	mtimer u_timer (
		.clk  (clk),
		.rst_n(rst_n),
		.bus  (tmr_bus.slave),
		.irq  (timer_irq)
	);

endmodule

`default_nettype wire

/* design/sram_slave.sv */
/*
 * sram_slave: 64-bit word memory with byte strobes
 * registered read data, responses held until accepted
 */
`timescale 1ns/100ps
`default_nettype none
`include "bus_macros.svh"

module sram_slave (
	input  logic      clk,
	input  logic      rst_n,
	axi_lite_if.slave bus
);

	localparam int IDX_W = $clog2(`MEM_WORDS);

	logic [`BUS_DATA_W-1:0] ram [`MEM_WORDS];
	logic                   rvalid_q, bvalid_q;
	logic [`BUS_DATA_W-1:0] rdata_q;
	logic [`BUS_ID_W-1:0]   rid_q, bid_q;
	logic                   rd_go, wr_go;

	assign bus.arready = ~rvalid_q;
	assign bus.awready = ~bvalid_q;
	assign rd_go       = bus.arvalid & bus.arready;
	assign wr_go       = bus.awvalid & bus.awready;

	assign bus.rvalid = rvalid_q;
	assign bus.rid    = rid_q;
	assign bus.rdata  = rdata_q;
	assign bus.rresp  = bus_pkg::RESP_OKAY;
	assign bus.bvalid = bvalid_q;
	assign bus.bid    = bid_q;
	assign bus.bresp  = bus_pkg::RESP_OKAY;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			if (rd_go)
				rvalid_q <= 1'b1;
			else if (bus.rready)
				rvalid_q <= 1'b0;
			if (wr_go)
				bvalid_q <= 1'b1;
			else if (bus.bready)
				bvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_go) begin
			rdata_q <= ram[bus.araddr[IDX_W+2:3]];
			rid_q   <= bus.arid;
		end
		if (wr_go) begin
			bid_q <= bus.awid;
			for (int i = 0; i < `BUS_STRB_W; i++) begin
				if (bus.wstrb[i])
					ram[bus.awaddr[IDX_W+2:3]][8*i +: 8] <= bus.wdata[8*i +: 8];
			end
		end
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/bus_pkg.sv
design/axi_lite_if.sv
design/bus_arbiter.sv
design/addr_router.sv
design/sram_slave.sv
design/mtimer.sv
design/soc_bus_top.sv
verif/tb_clkgen.sv
verif/soc_bus_sva.sv
verif/soc_bus_tb.sv

/* verif/bus_vectors.txt */
// op mst addr wdata strb exp_data exp_resp (hex, one transaction per line)
// op 0 read, 1 write, 2 read with the next line, 3 irq level, 4 irq wait, 5 read min, f end
1 1 00000010 1122334455667788 ff 0000000000000000 0
0 1 00000010 0000000000000000 00 1122334455667788 0
1 1 00000010 aabbccddeeff0011 0f 0000000000000000 0
0 0 00000010 0000000000000000 00 11223344eeff0011 0
1 1 00000ff8 0123456789abcdef ff 0000000000000000 0
1 1 00000ff8 ffffffffffffffff a0 0000000000000000 0
0 0 00000ff8 0000000000000000 00 ff23ff6789abcdef 0
1 1 00000100 5555aaaa5555aaaa ff 0000000000000000 0
2 1 00000100 0000000000000000 00 5555aaaa5555aaaa 0
0 0 00000010 0000000000000000 00 11223344eeff0011 0
0 1 10000000 0000000000000000 00 0000000000000000 3
1 1 10000000 0000000000001234 ff 0000000000000000 3
0 0 00001000 0000000000000000 00 0000000000000000 3
0 1 02000100 0000000000000000 00 0000000000000000 2
1 1 02000100 0000000000000001 ff 0000000000000000 2
1 1 0200bff8 0000000000000000 ff 0000000000000000 0
1 1 02004000 0000000000000064 ff 0000000000000000 0
3 0 00000000 0000000000000000 00 0000000000000000 0
4 0 00000000 000000000000006e 00 0000000000000000 0
1 1 02004000 ffffffffffffffff ff 0000000000000000 0
3 0 00000000 0000000000000000 00 0000000000000000 0
1 1 0200bff8 0000000100000000 ff 0000000000000000 0
5 1 0200bff8 0000000000000000 00 0000000100000000 0
f 0 00000000 0000000000000000 00 0000000000000000 0

/* verif/soc_bus_sva.sv */
/*
 * soc_bus_sva: handshake checks on the top-level master ports
 * bound into soc_bus_top
 */
`timescale 1ns/100ps
`default_nettype none
`include "bus_macros.svh"

module soc_bus_sva (
	input wire logic                   clk,
	input wire logic                   rst_n,
	input wire logic                   if_arvalid,
	input wire logic                   if_arready,
	input wire logic [`BUS_ADDR_W-1:0] if_araddr,
	input wire logic                   mem_arvalid,
	input wire logic                   mem_arready,
	input wire logic [`BUS_ADDR_W-1:0] mem_araddr,
	input wire logic                   mem_awvalid,
	input wire logic                   mem_awready,
	input wire logic [`BUS_ADDR_W-1:0] mem_awaddr,
	input wire logic [`BUS_DATA_W-1:0] mem_wdata,
	input wire logic                   if_rvalid,
	input wire logic                   if_rready,
	input wire logic                   mem_rvalid,
	input wire logic                   mem_rready,
	input wire logic                   mem_bvalid,
	input wire logic                   mem_bready
);

	// requests held with a stable payload until accepted
	a_if_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		if_arvalid && !if_arready |=> if_arvalid && $stable(if_araddr))
		else $error("fetch read request changed before arready");
	a_mem_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
		else $error("data read request changed before arready");
	a_mem_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_awvalid && !mem_awready |=> mem_awvalid && $stable(mem_awaddr)
			&& $stable(mem_wdata))
		else $error("write request changed before awready");

	// responses stay valid under back-pressure
	a_if_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		if_rvalid && !if_rready |=> if_rvalid)
		else $error("fetch rvalid dropped before rready");
	a_mem_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rvalid && !mem_rready |=> mem_rvalid)
		else $error("data rvalid dropped before rready");
	a_mem_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_bvalid && !mem_bready |=> mem_bvalid)
		else $error("bvalid dropped before bready");

	a_r_one_master: assert property (@(posedge clk) disable iff (!rst_n)
		!(if_rvalid && mem_rvalid))
		else $error("read response valid on both masters");

endmodule

bind soc_bus_top soc_bus_sva u_sva (.*);

`default_nettype wire

/* verif/soc_bus_tb.sv */
/*
 * soc_bus_tb: vector-driven transactions on both masters,
 * response checks, timer interrupt checks and a watchdog
 */
`timescale 1ns/100ps
`default_nettype none
`include "bus_macros.svh"

module soc_bus_tb;

	localparam int MAX_VEC        = 64;
	localparam int FIELDS         = 7;
	localparam int CYCLES_PER_VEC = 20;
	localparam logic [3:0] OP_READ      = 4'h0;
	localparam logic [3:0] OP_WRITE     = 4'h1;
	localparam logic [3:0] OP_PAIR      = 4'h2;
	localparam logic [3:0] OP_IRQ_LEVEL = 4'h3;
	localparam logic [3:0] OP_IRQ_WAIT  = 4'h4;
	localparam logic [3:0] OP_READ_MIN  = 4'h5;
	localparam logic [3:0] OP_END       = 4'hf;

	logic                   clk, rst_n;
	logic                   if_arvalid, if_arready, if_rvalid, if_rready;
	logic [`BUS_ID_W-1:0]   if_arid, if_rid;
	logic [`BUS_ADDR_W-1:0] if_araddr;
	logic [`BUS_DATA_W-1:0] if_rdata;
	bus_pkg::resp_t         if_rresp, mem_rresp, mem_bresp;
	logic                   mem_arvalid, mem_arready, mem_rvalid, mem_rready;
	logic [`BUS_ID_W-1:0]   mem_arid, mem_rid, mem_awid, mem_bid;
	logic [`BUS_ADDR_W-1:0] mem_araddr, mem_awaddr;
	logic [`BUS_DATA_W-1:0] mem_rdata, mem_wdata;
	logic                   mem_awvalid, mem_awready, mem_bvalid, mem_bready;
	logic [`BUS_STRB_W-1:0] mem_wstrb;
	logic                   timer_irq;

	logic [63:0] vec [FIELDS*MAX_VEC];
	int          done_at [MAX_VEC];
	int          num_vec = 0;
	int          cyc = 0;
	logic [31:0] lfsr_state = 32'h7e56_367d;

	tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

	soc_bus_top u_dut (.*);

	always @(posedge clk)
		cyc <= cyc + 1;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic pick_delay(output int d);
		d = 0;
		repeat (2) begin
			lfsr_state = lfsr_next(lfsr_state);
			d = (d << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	function automatic logic req_ready(input logic is_wr, input logic mst);
		return is_wr ? mem_awready : (mst ? mem_arready : if_arready);
	endfunction

	function automatic logic resp_valid(input logic is_wr, input logic mst);
		return is_wr ? mem_bvalid : (mst ? mem_rvalid : if_rvalid);
	endfunction

	task automatic set_valid(input logic is_wr, input logic mst, input logic v);
		if (is_wr)
			mem_awvalid = v;
		else if (mst)
			mem_arvalid = v;
		else
			if_arvalid = v;
	endtask

	task automatic set_ready(input logic is_wr, input logic mst, input logic v);
		if (is_wr)
			mem_bready = v;
		else if (mst)
			mem_rready = v;
		else
			if_rready = v;
	endtask

	// one bus transaction from vector idx with the index as its ID
	task automatic run_vector(input int idx, input logic alone);
		logic [3:0]  op;
		logic        mst;
		logic        is_wr;
		logic        at_least;
		logic [31:0] addr;
		logic [3:0]  id;
		logic [63:0] exp_data;
		logic [1:0]  exp_resp;
		logic [3:0]  got_id;
		logic [1:0]  got_resp;
		logic [63:0] got_data;
		string       pfx;
		int          start;
		int          delay;
		op       = vec[FIELDS*idx][3:0];
		mst      = vec[FIELDS*idx+1][0];
		addr     = vec[FIELDS*idx+2][31:0];
		exp_data = vec[FIELDS*idx+5];
		exp_resp = vec[FIELDS*idx+6][1:0];
		id       = idx[3:0];
		is_wr    = (op == OP_WRITE);
		at_least = (op == OP_READ_MIN);
		pfx      = is_wr ? "mem_b" : (mst ? "mem_r" : "if_r");
		@(posedge clk);
		#1;
		if (is_wr) begin
			mem_awaddr = addr;
			mem_awid   = id;
			mem_wdata  = vec[FIELDS*idx+3];
			mem_wstrb  = vec[FIELDS*idx+4][7:0];
		end else if (mst) begin
			mem_araddr = addr;
			mem_arid   = id;
		end else begin
			if_araddr = addr;
			if_arid   = id;
		end
		set_valid(is_wr, mst, 1'b1);
		start = cyc;
		@(negedge clk);
		while (!req_ready(is_wr, mst))
			@(negedge clk);
		@(posedge clk);
		#1;
		set_valid(is_wr, mst, 1'b0);
		pick_delay(delay);
		// no back-pressure, ready already up for the first response cycle
		if (delay == 0)
			set_ready(is_wr, mst, 1'b1);
		@(negedge clk);
		while (!resp_valid(is_wr, mst))
			@(negedge clk);
		if (alone)
			assert (cyc - start == 2) else begin
				$display("response valid came %0d cycles after request valid, not 2",
					cyc - start);
				abort_run();
			end
		if (delay > 0) begin
			repeat (delay) @(posedge clk);
			#1;
			set_ready(is_wr, mst, 1'b1);
			@(negedge clk);
		end
		got_id   = is_wr ? mem_bid : (mst ? mem_rid : if_rid);
		got_resp = is_wr ? mem_bresp : (mst ? mem_rresp : if_rresp);
		got_data = mst ? mem_rdata : if_rdata;
		assert (got_id == id) else begin
			$display("** Error: %sid = %h, expected %h", pfx, got_id, id);
			abort_run();
		end
		assert (got_resp == exp_resp) else begin
			$display("** Error: %sresp = %h, expected %h", pfx, got_resp, exp_resp);
			abort_run();
		end
		if (!is_wr) begin
			assert (at_least ? got_data >= exp_data : got_data == exp_data) else begin
				$display("** Error: %sdata = %h, expected %s%h", pfx, got_data,
					at_least ? "at least " : "", exp_data);
				abort_run();
			end
			assert (!(mst ? if_rvalid : mem_rvalid)) else begin
				$display("read response also shown to the other master");
				abort_run();
			end
		end
		@(posedge clk);
		#1;
		done_at[idx] = cyc;
		set_ready(is_wr, mst, 1'b0);
	endtask

	initial begin
		int i;
		int n;
		int waited;
		if_arvalid  = 1'b0;
		if_arid     = '0;
		if_araddr   = '0;
		if_rready   = 1'b0;
		mem_arvalid = 1'b0;
		mem_arid    = '0;
		mem_araddr  = '0;
		mem_rready  = 1'b0;
		mem_awvalid = 1'b0;
		mem_awid    = '0;
		mem_awaddr  = '0;
		mem_wdata   = '0;
		mem_wstrb   = '0;
		mem_bready  = 1'b0;
		$readmemh("verif/bus_vectors.txt", vec);
		n = 0;
		while (n < MAX_VEC && vec[FIELDS*n][3:0] != OP_END)
			n++;
		if (n == 0 || n == MAX_VEC) begin
			$display("vector file is empty or has no end marker");
			abort_run();
		end
		num_vec = n;
		wait (rst_n === 1'b1);
		i = 0;
		while (i < num_vec) begin
			case (vec[FIELDS*i][3:0])
				OP_PAIR: begin
					// both reads raise arvalid in the same cycle
					fork
						run_vector(i, 1'b0);
						run_vector(i + 1, 1'b0);
					join
					assert (vec[FIELDS*i+1][0] ? done_at[i] < done_at[i+1]
						: done_at[i+1] < done_at[i]) else begin
						$display("data read did not complete before the fetch read");
						abort_run();
					end
					i += 2;
				end
				OP_IRQ_LEVEL: begin
					@(negedge clk);
					assert (timer_irq == vec[FIELDS*i+5][0]) else begin
						$display("** Error: timer_irq = %h, expected %h",
							timer_irq, vec[FIELDS*i+5][0]);
						abort_run();
					end
					i++;
				end
				OP_IRQ_WAIT: begin
					waited = 0;
					@(negedge clk);
					while (!timer_irq && waited < vec[FIELDS*i+3]) begin
						@(negedge clk);
						waited++;
					end
					assert (timer_irq) else begin
						$display("timer_irq still low after %0d cycles", waited);
						abort_run();
					end
					i++;
				end
				OP_READ, OP_WRITE, OP_READ_MIN: begin
					run_vector(i, 1'b1);
					i++;
				end
				default: begin
					$display("unknown operation %h in vector %0d", vec[FIELDS*i][3:0], i);
					abort_run();
				end
			endcase
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

	// watchdog
	initial begin
		wait (num_vec > 0 && rst_n === 1'b1);
		repeat (num_vec * CYCLES_PER_VEC) @(posedge clk);
		$display("timeout after %0d cycles", num_vec * CYCLES_PER_VEC);
		abort_run();
	end

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
/*
 * testbench clock and power-on reset
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release just after a rising edge, like the other inputs
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

`default_nettype wire
